// ==== logic/fetch_pkg.sv ====
// Fetch stage package: address widths, opcode field, branch opcodes, queue entry type
package fetch_pkg;

	// Instruction address and word width
	localparam int ADDR_W = 32;

	// Opcode field inside an instruction word
	localparam int OPCODE_LSB = 21;
	localparam int OPCODE_MSB = 30;
	localparam int OPCODE_W   = OPCODE_MSB - OPCODE_LSB + 1;

	// Branch opcodes that trigger a BTB lookup
	localparam logic [OPCODE_W-1:0] OC_B   = 10'h0E0; // Immediate branch
	localparam logic [OPCODE_W-1:0] OC_BR  = 10'h0E1; // Register branch
	localparam logic [OPCODE_W-1:0] OC_BUR = 10'h0E2; // Unconditional register branch

	// One outstanding fetch request, oldest at the queue head
	typedef struct packed {
		logic              kernel_access; // Neither PSR[6:5] bit set
		logic              paging_ena;    // Either PSR[1:0] bit set
		logic [ADDR_W-1:0] addr;
	} fetch_queue_entry_t;

endpackage

// ==== logic/sync_fifo.sv ====
// Synchronous show-ahead FIFO with a typed payload, flush and full/empty flags
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = 8
) (
	input  logic     iCLOCK,
	input  logic     inRESET,
	input  logic     flush,
	input  logic     wr_en,
	input  payload_t wr_data,
	output logic     full,
	input  logic     rd_en,
	output payload_t rd_data,
	output logic     empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// Wraps at DEPTH, so DEPTH need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// Flush wins over both ports
	assign do_wr = wr_en && !full && !flush;
	assign do_rd = rd_en && !empty && !flush;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_inc(rd_ptr);
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	assign rd_data = mem[rd_ptr]; // Head is visible before the read strobe

endmodule

// ==== logic/branch_predictor.sv ====
// Direct-mapped branch target buffer with registered search and result training
`timescale 1ns/1ps

module branch_predictor #(
	parameter int ENTRIES = 8
) (
	input  logic                         iCLOCK,
	input  logic                         inRESET,
	input  logic                         search_stb,
	input  logic [fetch_pkg::ADDR_W-1:0] search_inst_addr,
	input  logic                         search_lock,
	output logic                         search_valid,
	output logic                         predict_taken,
	output logic [fetch_pkg::ADDR_W-1:0] predict_addr,
	input  logic                         result_valid,
	input  logic                         result_taken,
	input  logic [fetch_pkg::ADDR_W-1:0] result_target,
	input  logic [fetch_pkg::ADDR_W-1:0] result_inst_addr
);
	import fetch_pkg::*;

	// Address layout: tag | index | byte offset[1:0]
	localparam int IDX_W = $clog2(ENTRIES);
	localparam int TAG_W = ADDR_W - IDX_W - 2;

	logic [ENTRIES-1:0] entry_valid;
	logic [TAG_W-1:0]   entry_tag    [ENTRIES];
	logic [ADDR_W-1:0]  entry_target [ENTRIES];

	logic [IDX_W-1:0] search_idx;
	logic [TAG_W-1:0] search_tag;
	logic             search_hit;
	logic [IDX_W-1:0] result_idx;
	logic [TAG_W-1:0] result_tag;
	logic             result_match;

	assign search_idx = search_inst_addr[IDX_W+1:2];
	assign search_tag = search_inst_addr[ADDR_W-1:IDX_W+2];
	assign search_hit = entry_valid[search_idx] && (entry_tag[search_idx] == search_tag);

	assign result_idx   = result_inst_addr[IDX_W+1:2];
	assign result_tag   = result_inst_addr[ADDR_W-1:IDX_W+2];
	assign result_match = entry_valid[result_idx] && (entry_tag[result_idx] == result_tag);

	// Valid bits
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			entry_valid <= '0;
		end else if (result_valid) begin
			if (result_taken)
				entry_valid[result_idx] <= 1'b1;
			else if (result_match)
				entry_valid[result_idx] <= 1'b0; // Not taken any more, drop it
		end
	end

	// Tag and target only change on a taken result
	always_ff @(posedge iCLOCK) begin
		if (result_valid && result_taken) begin
			entry_tag[result_idx]    <= result_tag;
			entry_target[result_idx] <= result_target;
		end
	end

	// Search result, frozen while decode is stalled
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			search_valid  <= 1'b0;
			predict_taken <= 1'b0;
		end else if (!search_lock) begin
			search_valid  <= search_stb;
			predict_taken <= search_stb && search_hit;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!search_lock && search_stb)
			predict_addr <= entry_target[search_idx];
	end

endmodule

// ==== logic/fetch.sv ====
// Fetch unit: PC state machine, request queue, BTB lookup and decode output buffer
`timescale 1ns/1ps

module fetch #(
	parameter int QUEUE_DEPTH = 8,
	parameter int BTB_ENTRIES = 8,
	parameter int PREDICT_ENA = 1
) (
	input  logic                         iCLOCK,
	input  logic                         inRESET,
	input  logic [fetch_pkg::ADDR_W-1:0] psr,
	input  logic                         exception_event,
	input  logic                         exception_addr_set,
	input  logic [fetch_pkg::ADDR_W-1:0] exception_addr,
	input  logic                         result_valid,
	input  logic                         result_taken,
	input  logic [fetch_pkg::ADDR_W-1:0] result_target,
	input  logic [fetch_pkg::ADDR_W-1:0] result_inst_addr,
	output logic                         predict_flush,
	output logic                         fetch_req,
	output logic [fetch_pkg::ADDR_W-1:0] fetch_addr,
	input  logic                         fetch_lock,
	input  logic                         inst_valid,
	input  logic [fetch_pkg::ADDR_W-1:0] inst,
	input  logic                         pagefault,
	output logic                         prev_lock,
	output logic                         next_inst_valid,
	output logic [fetch_pkg::ADDR_W-1:0] next_inst,
	output logic [fetch_pkg::ADDR_W-1:0] next_pc,
	output logic                         next_pagefault,
	output logic                         next_paging_ena,
	output logic                         next_kernel_access,
	output logic                         next_branch_predict,
	output logic [fetch_pkg::ADDR_W-1:0] next_branch_predict_addr,
	input  logic                         fetch_stop,
	input  logic                         next_lock
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		ST_RESET_START,
		ST_FETCHING,
		ST_EXCEPTION_WAIT
	} pc_state_t;

	pc_state_t          state;
	logic [ADDR_W-1:0]  pc;
	logic               issue;
	logic               pop;
	logic               capture;
	logic               flush;
	logic               pipe_clear;
	logic               search_stb;
	logic               queue_full;
	logic               queue_empty;
	fetch_queue_entry_t queue_wr_data;
	fetch_queue_entry_t queue_head;
	logic               btb_valid;
	logic               btb_taken;
	logic [ADDR_W-1:0]  btb_target;

	function automatic logic is_branch(input logic [ADDR_W-1:0] word);
		logic [OPCODE_W-1:0] opcode;
		opcode = word[OPCODE_MSB:OPCODE_LSB];
		return (opcode == OC_B) || (opcode == OC_BR) || (opcode == OC_BUR);
	endfunction

	assign flush      = (PREDICT_ENA != 0) && btb_valid && btb_taken && !next_lock;
	assign pipe_clear = exception_event || flush;

	// Source holds its word while prev_lock is high, so pop only when decode can take it
	assign pop        = inst_valid && !next_lock && !queue_empty;
	assign capture    = pop && !pipe_clear;
	assign search_stb = capture && is_branch(inst); // No lookup for a word being flushed

	assign issue = (state == ST_FETCHING) && !exception_event && !exception_addr_set &&
		!flush && !queue_full && !fetch_lock && !fetch_stop;

	assign fetch_req     = issue;
	assign fetch_addr    = pc;
	assign prev_lock     = next_lock;
	assign predict_flush = flush;

	assign queue_wr_data.addr          = pc;
	assign queue_wr_data.paging_ena    = psr[1] || psr[0];
	assign queue_wr_data.kernel_access = !(psr[6] || psr[5]);

	sync_fifo #(
		.payload_t (fetch_queue_entry_t),
		.DEPTH     (QUEUE_DEPTH)
	) queue_i (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.flush   (pipe_clear),
		.wr_en   (issue),
		.wr_data (queue_wr_data),
		.full    (queue_full),
		.rd_en   (pop),
		.rd_data (queue_head),
		.empty   (queue_empty)
	);

	branch_predictor #(
		.ENTRIES (BTB_ENTRIES)
	) btb_i (
		.iCLOCK           (iCLOCK),
		.inRESET          (inRESET),
		.search_stb       (search_stb),
		.search_inst_addr (queue_head.addr), // Head entry belongs to the returning word
		.search_lock      (next_lock),
		.search_valid     (btb_valid),
		.predict_taken    (btb_taken),
		.predict_addr     (btb_target),
		.result_valid     (result_valid),
		.result_taken     (result_taken),
		.result_target    (result_target),
		.result_inst_addr (result_inst_addr)
	);

	// PC state machine; address set beats exception, exception beats redirect
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_RESET_START;
			pc    <= '0;
		end else if (exception_addr_set) begin
			state <= ST_FETCHING;
			pc    <= {exception_addr[ADDR_W-1:1], 1'b0};
		end else if (exception_event) begin
			state <= ST_EXCEPTION_WAIT;
		end else if (flush) begin
			state <= ST_FETCHING;
			pc    <= btb_target;
		end else begin
			case (state)
				ST_RESET_START: begin
					state <= ST_FETCHING;
					pc    <= '0;
				end
				ST_FETCHING: begin
					if (issue)
						pc <= pc + 32'd4;
				end
				ST_EXCEPTION_WAIT: state <= ST_EXCEPTION_WAIT; // Left only by an address set
				default: state <= ST_RESET_START;
			endcase
		end
	end

	// Output buffer valid
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			next_inst_valid <= 1'b0;
		else if (pipe_clear)
			next_inst_valid <= 1'b0;
		else if (!next_lock)
			next_inst_valid <= pop;
	end

	// Output buffer payload
	always_ff @(posedge iCLOCK) begin
		if (capture) begin
			next_inst          <= inst;
			next_pc            <= queue_head.addr + 32'd4;
			next_pagefault     <= pagefault;
			next_paging_ena    <= queue_head.paging_ena;
			next_kernel_access <= queue_head.kernel_access;
		end
	end

	// Prediction travels alongside the branch word in the buffer
	assign next_branch_predict      = (PREDICT_ENA != 0) && btb_valid && btb_taken;
	assign next_branch_predict_addr = (PREDICT_ENA != 0) ? btb_target : '0;

endmodule

// ==== logic/fetch_top.sv ====
// Fetch stage top level with queue depth, BTB size and prediction enable
`timescale 1ns/1ps

module fetch_top #(
	parameter int QUEUE_DEPTH = 8,
	parameter int BTB_ENTRIES = 8,
	parameter int PREDICT_ENA = 1
) (
	input  logic                         iCLOCK,
	input  logic                         inRESET,
	input  logic [fetch_pkg::ADDR_W-1:0] psr,
	input  logic                         exception_event,
	input  logic                         exception_addr_set,
	input  logic [fetch_pkg::ADDR_W-1:0] exception_addr,
	input  logic                         result_valid,
	input  logic                         result_taken,
	input  logic [fetch_pkg::ADDR_W-1:0] result_target,
	input  logic [fetch_pkg::ADDR_W-1:0] result_inst_addr,
	output logic                         predict_flush,
	output logic                         fetch_req,
	output logic [fetch_pkg::ADDR_W-1:0] fetch_addr,
	input  logic                         fetch_lock,
	input  logic                         inst_valid,
	input  logic [fetch_pkg::ADDR_W-1:0] inst,
	input  logic                         pagefault,
	output logic                         prev_lock,
	output logic                         next_inst_valid,
	output logic [fetch_pkg::ADDR_W-1:0] next_inst,
	output logic [fetch_pkg::ADDR_W-1:0] next_pc,
	output logic                         next_pagefault,
	output logic                         next_paging_ena,
	output logic                         next_kernel_access,
	output logic                         next_branch_predict,
	output logic [fetch_pkg::ADDR_W-1:0] next_branch_predict_addr,
	input  logic                         fetch_stop,
	input  logic                         next_lock
);

	fetch #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.BTB_ENTRIES (BTB_ENTRIES),
		.PREDICT_ENA (PREDICT_ENA)
	) fetch_i (
		.iCLOCK                   (iCLOCK),
		.inRESET                  (inRESET),
		.psr                      (psr),
		.exception_event          (exception_event),
		.exception_addr_set       (exception_addr_set),
		.exception_addr           (exception_addr),
		.result_valid             (result_valid),
		.result_taken             (result_taken),
		.result_target            (result_target),
		.result_inst_addr         (result_inst_addr),
		.predict_flush            (predict_flush), // Source drops outstanding words on this
		.fetch_req                (fetch_req),
		.fetch_addr               (fetch_addr),
		.fetch_lock               (fetch_lock),
		.inst_valid               (inst_valid),
		.inst                     (inst),
		.pagefault                (pagefault),
		.prev_lock                (prev_lock),
		.next_inst_valid          (next_inst_valid),
		.next_inst                (next_inst),
		.next_pc                  (next_pc),
		.next_pagefault           (next_pagefault),
		.next_paging_ena          (next_paging_ena),
		.next_kernel_access       (next_kernel_access),
		.next_branch_predict      (next_branch_predict),
		.next_branch_predict_addr (next_branch_predict_addr),
		.fetch_stop               (fetch_stop),
		.next_lock                (next_lock)
	);

endmodule

// ==== tests/imem_model.sv ====
// Behavioral instruction source with two-cycle latency, hold input, fault window and branch word
`timescale 1ns/1ps

module imem_model #(
	parameter logic [31:0] BRANCH_ADDR = 32'h400,
	parameter logic [31:0] FAULT_LO    = 32'h340,
	parameter logic [31:0] FAULT_HI    = 32'h35c
) (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        fetch_req,
	input  logic [31:0] fetch_addr,
	input  logic        fetch_lock,
	input  logic        prev_lock,
	input  logic        drop,
	output logic        inst_valid,
	output logic [31:0] inst,
	output logic        pagefault
);
	import fetch_pkg::*;

	logic [31:0] pend_addr [$];
	int          pend_time [$];
	int          cycle;
	logic [31:0] head;

	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pend_addr.delete();
			pend_time.delete();
			cycle      <= 0;
			inst_valid <= 1'b0;
			inst       <= '0;
			pagefault  <= 1'b0;
		end else begin
			cycle <= cycle + 1;
			if (drop) begin // Outstanding words are discarded
				pend_addr.delete();
				pend_time.delete();
				inst_valid <= 1'b0;
			end else begin
				if (fetch_req && !fetch_lock) begin
					pend_addr.push_back(fetch_addr);
					pend_time.push_back(cycle);
				end
				if (!prev_lock) begin // Otherwise hold the current word
					if (pend_addr.size() > 0 && pend_time[0] < cycle) begin
						head = pend_addr.pop_front();
						void'(pend_time.pop_front());
						inst_valid <= 1'b1;
						inst       <= (head == BRANCH_ADDR) ? {1'b0, OC_B, 21'h0}
							: (head ^ 32'ha5a5_0000);
						pagefault  <= (head >= FAULT_LO) && (head <= FAULT_HI);
					end else begin
						inst_valid <= 1'b0;
					end
				end
			end
		end
	end

endmodule

// ==== tests/tb_fetch_top.sv ====
// Testbench for fetch_top: clock, reset, in-order scoreboard and directed tests
`timescale 1ns/1ps

module tb_fetch_top;
	import fetch_pkg::*;

	localparam logic [31:0] BRANCH_ADDR = 32'h400;
	localparam logic [31:0] TARGET_ADDR = 32'h800;

	logic        clk;
	logic        rst_n;
	logic [31:0] psr;
	logic        exception_event;
	logic        exception_addr_set;
	logic [31:0] exception_addr;
	logic        result_valid;
	logic        result_taken;
	logic [31:0] result_target;
	logic [31:0] result_inst_addr;
	logic        predict_flush;
	logic        fetch_req;
	logic [31:0] fetch_addr;
	logic        fetch_lock;
	logic        inst_valid;
	logic [31:0] inst;
	logic        pagefault;
	logic        prev_lock;
	logic        next_inst_valid;
	logic [31:0] next_inst;
	logic [31:0] next_pc;
	logic        next_pagefault;
	logic        next_paging_ena;
	logic        next_kernel_access;
	logic        next_branch_predict;
	logic [31:0] next_branch_predict_addr;
	logic        fetch_stop;
	logic        next_lock;

	// Scoreboard state
	logic [31:0] exp_addr [$];
	logic        exp_paging [$];
	logic        exp_kernel [$];
	logic [31:0] exp_next_req;
	logic [31:0] head_addr;
	logic        head_paging;
	logic        head_kernel;
	logic        hold_check;
	logic [99:0] snapshot;
	logic [31:0] watch_addr;
	logic        watch_hit;
	logic        watch_predict;
	logic [31:0] watch_predict_addr;
	int          errors;
	int          flush_count;
	int          pf_seen;
	int          flushes_before;
	integer      seed;

	fetch_top #(
		.QUEUE_DEPTH (8),
		.BTB_ENTRIES (8),
		.PREDICT_ENA (1)
	) dut_i (
		.iCLOCK (clk), .inRESET (rst_n), .psr (psr),
		.exception_event (exception_event), .exception_addr_set (exception_addr_set),
		.exception_addr (exception_addr), .result_valid (result_valid),
		.result_taken (result_taken), .result_target (result_target),
		.result_inst_addr (result_inst_addr), .predict_flush (predict_flush),
		.fetch_req (fetch_req), .fetch_addr (fetch_addr), .fetch_lock (fetch_lock),
		.inst_valid (inst_valid), .inst (inst), .pagefault (pagefault),
		.prev_lock (prev_lock), .next_inst_valid (next_inst_valid),
		.next_inst (next_inst), .next_pc (next_pc), .next_pagefault (next_pagefault),
		.next_paging_ena (next_paging_ena), .next_kernel_access (next_kernel_access),
		.next_branch_predict (next_branch_predict),
		.next_branch_predict_addr (next_branch_predict_addr),
		.fetch_stop (fetch_stop), .next_lock (next_lock)
	);

	imem_model #(
		.BRANCH_ADDR (BRANCH_ADDR)
	) imem_i (
		.iCLOCK (clk), .inRESET (rst_n), .fetch_req (fetch_req),
		.fetch_addr (fetch_addr), .fetch_lock (fetch_lock), .prev_lock (prev_lock),
		.drop (predict_flush || exception_event), .inst_valid (inst_valid),
		.inst (inst), .pagefault (pagefault)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Word the source returns for an address
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		if (addr == BRANCH_ADDR)
			return {1'b0, OC_B, 21'h0};
		return addr ^ 32'ha5a5_0000;
	endfunction

	function automatic logic in_fault_window(input logic [31:0] addr);
		return (addr >= 32'h340) && (addr <= 32'h35c);
	endfunction

	task automatic check_word();
		if (exp_addr.size() == 0) begin
			errors++;
			$display("Error at %0t: unexpected word %h", $time, next_inst);
		end else begin
			head_addr   = exp_addr.pop_front();
			head_paging = exp_paging.pop_front();
			head_kernel = exp_kernel.pop_front();
			if (next_inst !== expected_word(head_addr) || next_pc !== head_addr + 32'd4 ||
				next_pagefault !== in_fault_window(head_addr) ||
				next_paging_ena !== head_paging || next_kernel_access !== head_kernel) begin
				errors++;
				$display("Error at %0t: word %h pc %h pf %b flags %b%b for address %h",
					$time, next_inst, next_pc, next_pagefault, next_paging_ena,
					next_kernel_access, head_addr);
			end
			if (in_fault_window(head_addr))
				pf_seen++;
			if (head_addr == watch_addr) begin
				watch_hit          = 1'b1;
				watch_predict      = next_branch_predict;
				watch_predict_addr = next_branch_predict_addr;
			end
		end
	endtask

	// Request order, output order and hold checks, sampled on the rising edge
	always @(posedge clk) begin
		if (rst_n) begin
			if (fetch_stop && fetch_req) begin
				errors++;
				$display("Error at %0t: request issued while fetch_stop is high", $time);
			end
			if (prev_lock !== next_lock) begin
				errors++;
				$display("Error at %0t: prev_lock %b, next_lock %b", $time, prev_lock,
					next_lock);
			end
			if (hold_check && snapshot !== {next_inst, next_pc, next_branch_predict_addr,
				next_pagefault, next_paging_ena, next_kernel_access, next_branch_predict}) begin
				errors++;
				$display("Error at %0t: outputs changed while next_lock was high", $time);
			end
			hold_check = next_lock && next_inst_valid && !exception_event;
			snapshot = {next_inst, next_pc, next_branch_predict_addr, next_pagefault,
				next_paging_ena, next_kernel_access, next_branch_predict};
			if (next_inst_valid && !next_lock && !exception_event)
				check_word();
			if (predict_flush)
				flush_count++;
			if (exception_event || predict_flush) begin // Everything in flight is dropped
				exp_addr.delete();
				exp_paging.delete();
				exp_kernel.delete();
			end
			if (exception_addr_set) begin
				exp_next_req = {exception_addr[31:1], 1'b0};
			end else if (predict_flush) begin
				exp_next_req = TARGET_ADDR; // Only trained branch target
			end else if (fetch_req && !fetch_lock) begin
				if (fetch_addr !== exp_next_req) begin
					errors++;
					$display("Error at %0t: request %h, expected %h", $time, fetch_addr,
						exp_next_req);
				end
				exp_addr.push_back(fetch_addr);
				exp_paging.push_back(psr[1] || psr[0]);
				exp_kernel.push_back(!(psr[6] || psr[5]));
				exp_next_req = fetch_addr + 32'd4;
			end
		end
	end

	task automatic abort_on_timeout(input string what);
		$display("Timeout waiting for %s", what);
		$display("sim failed");
		$finish;
	endtask

	task automatic wait_word(input logic [31:0] addr);
		watch_addr = addr;
		watch_hit  = 1'b0;
		for (int i = 0; i < 2000 && !watch_hit; i++) begin
			@(posedge clk);
			#1;
		end
		if (!watch_hit)
			abort_on_timeout($sformatf("word at %h", addr));
	endtask

	task automatic restart_at(input logic [31:0] addr);
		@(posedge clk);
		#1;
		exception_addr_set = 1'b1;
		exception_addr     = addr;
		@(posedge clk);
		#1;
		exception_addr_set = 1'b0;
	endtask

	task automatic train_branch(input logic taken);
		@(posedge clk);
		#1;
		result_valid     = 1'b1;
		result_taken     = taken;
		result_target    = TARGET_ADDR;
		result_inst_addr = BRANCH_ADDR;
		@(posedge clk);
		#1;
		result_valid = 1'b0;
	endtask

	task automatic test_sequential();
		wait_word(32'h10);
		psr = 32'h0000_0023; // Paging on, user mode
		wait_word(32'h40);
	endtask

	task automatic test_backpressure();
		for (int i = 0; i < 150; i++) begin
			@(posedge clk);
			#1;
			fetch_lock = (($random(seed) & 3) == 0);
			next_lock  = (($random(seed) & 3) == 0);
		end
		fetch_lock = 1'b0;
		next_lock  = 1'b0;
		fetch_stop = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		fetch_stop = 1'b0;
		psr        = 32'h0;
	endtask

	task automatic test_exception();
		@(posedge clk);
		#1;
		exception_event = 1'b1;
		for (int i = 0; i < 6; i++) begin
			@(posedge clk);
			#1;
			if (fetch_req || next_inst_valid) begin
				errors++;
				$display("Error at %0t: activity during exception_event", $time);
			end
		end
		exception_event = 1'b0;
		pf_seen = 0;
		restart_at(32'h301); // Bit 0 must be cleared
		wait_word(32'h300);
	endtask

	task automatic test_pagefault();
		wait_word(32'h360);
		if (pf_seen != 8) begin
			errors++;
			$display("Error at %0t: %0d faulting words, expected 8", $time, pf_seen);
		end
	endtask

	task automatic test_branch();
		wait_word(BRANCH_ADDR);
		if (watch_predict || flush_count != 0) begin
			errors++;
			$display("Error at %0t: untrained branch was predicted", $time);
		end
		train_branch(1'b1);
		restart_at(32'h3f0);
		wait_word(BRANCH_ADDR);
		if (!watch_predict || watch_predict_addr !== TARGET_ADDR || flush_count != 1) begin
			errors++;
			$display("Error at %0t: prediction %b to %h, flushes %0d", $time,
				watch_predict, watch_predict_addr, flush_count);
		end
		wait_word(TARGET_ADDR);
		flushes_before = flush_count;
		train_branch(1'b0);
		restart_at(32'h3f0);
		wait_word(BRANCH_ADDR + 32'd4);
		if (flush_count != flushes_before) begin
			errors++;
			$display("Error at %0t: flush after a not-taken result", $time);
		end
	endtask

	initial begin
		seed               = 32'h15c7;
		errors             = 0;
		flush_count        = 0;
		pf_seen            = 0;
		hold_check         = 1'b0;
		snapshot           = '0;
		exp_next_req       = 32'h0;
		watch_addr         = 32'hffff_ffff;
		watch_hit          = 1'b0;
		rst_n              = 1'b0;
		psr                = 32'h0;
		exception_event    = 1'b0;
		exception_addr_set = 1'b0;
		exception_addr     = 32'h0;
		result_valid       = 1'b0;
		result_taken       = 1'b0;
		result_target      = 32'h0;
		result_inst_addr   = 32'h0;
		fetch_lock         = 1'b0;
		fetch_stop         = 1'b0;
		next_lock          = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_sequential();
		test_backpressure();
		test_exception();
		test_pagefault();
		test_branch();

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/fetch_pkg.sv
logic/sync_fifo.sv
logic/branch_predictor.sv
logic/fetch.sv
logic/fetch_top.sv
tests/imem_model.sv
tests/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_fetch_top -o sim_fetch
./obj_dir/sim_fetch | tee sim.log

if grep -q "^sim passed$" sim.log; then
	exit 0
else
	exit 1
fi
